// File: issue_stage.f
+incdir+logic
logic/issue_pkg.sv
logic/sync_fifo.sv
logic/credit_counter.sv
logic/instr_decoder.sv
logic/dispatch_fsm.sv
logic/issue_stage_top.sv
verification/issue_stage_tb.sv

// File: logic/credit_counter.sv
`timescale 1ns/1ns
`default_nettype none

module credit_counter #(
    parameter int MAX_CREDITS = 4
) (
    input  logic clk,
    input  logic reset_i,
    input  logic consume_i,
    input  logic return_i,
    output logic avail_o,
    output logic all_returned_o
);

    localparam int CNT_W = $clog2(MAX_CREDITS + 1);

    logic [CNT_W-1:0] count;

    // counter starts full, every credit is held by the issue stage
    always_ff @(posedge clk) begin
        if (reset_i) begin
            count <= CNT_W'(MAX_CREDITS);
        end else if (consume_i && !return_i) begin
            count <= count - 1'b1;
        end else if (return_i && !consume_i) begin
            count <= count + 1'b1;
        end
    end

    assign avail_o        = (count != '0);
    assign all_returned_o = (count == CNT_W'(MAX_CREDITS));

endmodule

`default_nettype wire

// File: logic/dispatch_fsm.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_consts.svh"

module dispatch_fsm (
    input  logic                          clk,
    input  logic                          reset_i,
    input  issue_pkg::ctl_word_t          head_i,
    input  logic                          head_valid_i,
    input  logic                          rob_avail_i,
    input  logic                          rob_all_returned_i,
    input  logic [`ISSUE_NUM_ALU_RS-1:0]  rs_avail_i,
    input  logic                          br_avail_i,
    output issue_pkg::issue_pkt_t         issue_o,
    output logic                          pop_o,
    output logic [`ISSUE_NUM_ALU_RS-1:0]  rs_consume_o,
    output logic                          br_consume_o,
    output logic                          rob_consume_o
);
    import issue_pkg::*;

    typedef enum logic {
        ISSUE,
        DRAIN
    } state_t;

    state_t   state_q;
    state_t   state_d;
    logic     alu_found;
    station_t alu_sel;
    station_t station;
    logic     is_br;
    logic     fire;

    // lowest numbered ALU station still holding a credit
    always_comb begin
        alu_found = 1'b0;
        alu_sel   = RS_ALU0;
        for (int i = `ISSUE_NUM_ALU_RS - 1; i >= 0; i--) begin
            if (rs_avail_i[i]) begin
                alu_found = 1'b1;
                alu_sel   = station_t'(3'(i));
            end
        end
    end

    assign is_br = (head_i.op == OP_BRANCH) || (head_i.op == OP_JUMP);

    always_comb begin
        state_d = state_q;
        fire    = 1'b0;
        station = alu_sel;
        case (state_q)
            ISSUE: begin
                if (head_valid_i) begin
                    if (head_i.op == OP_SYSTEM) begin
                        // hold the system op until the ROB is empty
                        state_d = DRAIN;
                    end else if (is_br) begin
                        station = RS_BR;
                        fire    = rob_avail_i && br_avail_i;
                    end else begin
                        fire = rob_avail_i && alu_found;
                    end
                end
            end
            DRAIN: begin
                if (head_valid_i && rob_all_returned_i && alu_found) begin
                    fire    = 1'b1;
                    state_d = ISSUE;
                end
            end
            default: begin
                state_d = ISSUE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ISSUE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        issue_o.valid         = fire;
        issue_o.station       = station;
        // stores, branches and system ops never write rd
        issue_o.regfile_alloc = (head_i.rd != '0) && (head_i.op != OP_STORE) &&
                                (head_i.op != OP_BRANCH) && (head_i.op != OP_SYSTEM);
        issue_o.ctl           = head_i;
        for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
            rs_consume_o[i] = fire && (station == station_t'(3'(i)));
        end
    end

    assign pop_o         = fire;
    assign rob_consume_o = fire;
    assign br_consume_o  = fire && (station == RS_BR);

endmodule

`default_nettype wire

// File: logic/instr_decoder.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_consts.svh"

module instr_decoder (
    input  issue_pkg::fetch_pkt_t fetch_pkt_i,
    output issue_pkg::ctl_word_t  ctl_o
);
    import issue_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    logic [`ISSUE_XLEN-1:0] ins;
    logic [`ISSUE_XLEN-1:0] imm_i;
    logic [`ISSUE_XLEN-1:0] imm_s;
    logic [`ISSUE_XLEN-1:0] imm_b;
    logic [`ISSUE_XLEN-1:0] imm_u;
    logic [`ISSUE_XLEN-1:0] imm_j;

    assign ins = fetch_pkt_i.instr;

    // sign-extended immediates for each format
    assign imm_i = {{20{ins[31]}}, ins[31:20]};
    assign imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
    assign imm_b = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
    assign imm_u = {ins[31:12], 12'b0};
    assign imm_j = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};

    always_comb begin
        ctl_o.funct3    = ins[14:12];
        ctl_o.funct7_5  = ins[30];
        ctl_o.rs1       = ins[19:15];
        ctl_o.rs2       = ins[24:20];
        ctl_o.rd        = ins[11:7];
        ctl_o.pc        = fetch_pkt_i.pc;
        ctl_o.next_pc   = fetch_pkt_i.pc + `ISSUE_XLEN'd4;
        ctl_o.instr     = ins;
        // unknown opcodes fall through as an ALU op with no operands
        ctl_o.op        = OP_ALU;
        ctl_o.imm       = '0;
        ctl_o.rs1_valid = 1'b0;
        ctl_o.rs2_valid = 1'b0;

        case (ins[6:0])
            OPC_LUI, OPC_AUIPC: begin
                ctl_o.op  = OP_UPPER;
                ctl_o.imm = imm_u;
            end
            OPC_JAL: begin
                ctl_o.op  = OP_JUMP;
                ctl_o.imm = imm_j;
            end
            OPC_JALR: begin
                ctl_o.op        = OP_JUMP;
                ctl_o.imm       = imm_i;
                ctl_o.rs1_valid = 1'b1;
            end
            OPC_BRANCH: begin
                ctl_o.op        = OP_BRANCH;
                ctl_o.imm       = imm_b;
                ctl_o.rs1_valid = 1'b1;
                ctl_o.rs2_valid = 1'b1;
            end
            OPC_LOAD: begin
                ctl_o.op        = OP_LOAD;
                ctl_o.imm       = imm_i;
                ctl_o.rs1_valid = 1'b1;
            end
            OPC_STORE: begin
                ctl_o.op        = OP_STORE;
                ctl_o.imm       = imm_s;
                ctl_o.rs1_valid = 1'b1;
                ctl_o.rs2_valid = 1'b1;
            end
            OPC_IMM: begin
                ctl_o.imm       = imm_i;
                ctl_o.rs1_valid = 1'b1;
            end
            OPC_REG: begin
                ctl_o.rs1_valid = 1'b1;
                ctl_o.rs2_valid = 1'b1;
            end
            OPC_FENCE, OPC_SYSTEM: begin
                ctl_o.op  = OP_SYSTEM;
                ctl_o.imm = imm_i;
            end
            default: begin
                ctl_o.op = OP_ALU;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: logic/issue_consts.svh
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// fetch buffer entries, also the fetch credits granted after reset
`define ISSUE_FETCH_DEPTH 4

// in-order instruction queue entries
`define ISSUE_IQ_DEPTH 8

// reorder buffer entries
`define ISSUE_ROB_CREDITS 8

// entries per ALU station and in the branch station
`define ISSUE_RS_CREDITS 1
`define ISSUE_BR_CREDITS 2
`define ISSUE_NUM_ALU_RS 4

// datapath and register index widths
`define ISSUE_XLEN 32
`define ISSUE_REG_W 5

`endif

// File: logic/issue_pkg.sv
`default_nettype none

`include "issue_consts.svh"

package issue_pkg;

    // coarse class of an instruction, drives station choice
    typedef enum logic [2:0] {
        OP_ALU    = 3'd0,
        OP_LOAD   = 3'd1,
        OP_STORE  = 3'd2,
        OP_BRANCH = 3'd3,
        OP_JUMP   = 3'd4,
        OP_UPPER  = 3'd5,
        OP_SYSTEM = 3'd6
    } op_class_t;

    // destination station of an issued instruction
    typedef enum logic [2:0] {
        RS_ALU0 = 3'd0,
        RS_ALU1 = 3'd1,
        RS_ALU2 = 3'd2,
        RS_ALU3 = 3'd3,
        RS_BR   = 3'd4
    } station_t;

    typedef struct packed {
        logic [`ISSUE_XLEN-1:0] instr;
        logic [`ISSUE_XLEN-1:0] pc;
    } fetch_pkt_t;

    typedef struct packed {
        op_class_t               op;
        logic [2:0]              funct3;
        logic                    funct7_5;
        logic [`ISSUE_REG_W-1:0] rs1;
        logic                    rs1_valid;
        logic [`ISSUE_REG_W-1:0] rs2;
        logic                    rs2_valid;
        logic [`ISSUE_XLEN-1:0]  imm;
        logic [`ISSUE_REG_W-1:0] rd;
        logic [`ISSUE_XLEN-1:0]  pc;
        logic [`ISSUE_XLEN-1:0]  next_pc;
        logic [`ISSUE_XLEN-1:0]  instr;
    } ctl_word_t;

    typedef struct packed {
        logic      valid;
        station_t  station;
        logic      regfile_alloc;
        ctl_word_t ctl;
    } issue_pkt_t;

endpackage

`default_nettype wire

// File: logic/issue_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_consts.svh"

module issue_stage_top (
    input  logic                         clk,
    input  logic                         reset_i,
    input  logic                         fetch_valid_i,
    input  issue_pkg::fetch_pkt_t        fetch_pkt_i,
    output logic                         fetch_credit_o,
    input  logic                         rob_credit_i,
    input  logic [`ISSUE_NUM_ALU_RS-1:0] rs_credit_i,
    input  logic                         br_credit_i,
    output issue_pkg::issue_pkt_t        issue_o
);
    import issue_pkg::*;

    fetch_pkt_t                   fb_head;
    logic                         fb_empty;
    logic                         fb_pop;
    ctl_word_t                    dec_ctl;
    ctl_word_t                    iq_head;
    logic                         iq_empty;
    logic                         iq_full;
    logic                         iq_pop;
    logic                         rob_avail;
    logic                         rob_all_returned;
    logic                         rob_consume;
    logic [`ISSUE_NUM_ALU_RS-1:0] rs_avail;
    logic [`ISSUE_NUM_ALU_RS-1:0] rs_consume;
    logic                         br_avail;
    logic                         br_consume;

    // move decoded words into the queue whenever there is room
    assign fb_pop         = !fb_empty && !iq_full;
    assign fetch_credit_o = fb_pop;

    // fetch pushes only with a credit in hand, so the buffer never overflows
    sync_fifo #(.DTYPE(fetch_pkt_t), .DEPTH(`ISSUE_FETCH_DEPTH)) fetch_buffer (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (fetch_valid_i),
        .data_i  (fetch_pkt_i),
        .pop_i   (fb_pop),
        .data_o  (fb_head),
        .empty_o (fb_empty),
        .full_o  ()
    );

    instr_decoder decoder (
        .fetch_pkt_i (fb_head),
        .ctl_o       (dec_ctl)
    );

    sync_fifo #(.DTYPE(ctl_word_t), .DEPTH(`ISSUE_IQ_DEPTH)) instr_queue (
        .clk     (clk),
        .reset_i (reset_i),
        .push_i  (fb_pop),
        .data_i  (dec_ctl),
        .pop_i   (iq_pop),
        .data_o  (iq_head),
        .empty_o (iq_empty),
        .full_o  (iq_full)
    );

    credit_counter #(.MAX_CREDITS(`ISSUE_ROB_CREDITS)) rob_credits (
        .clk            (clk),
        .reset_i        (reset_i),
        .consume_i      (rob_consume),
        .return_i       (rob_credit_i),
        .avail_o        (rob_avail),
        .all_returned_o (rob_all_returned)
    );

    for (genvar g = 0; g < `ISSUE_NUM_ALU_RS; g++) begin : g_alu_rs
        credit_counter #(.MAX_CREDITS(`ISSUE_RS_CREDITS)) rs_credits (
            .clk            (clk),
            .reset_i        (reset_i),
            .consume_i      (rs_consume[g]),
            .return_i       (rs_credit_i[g]),
            .avail_o        (rs_avail[g]),
            .all_returned_o ()
        );
    end

    credit_counter #(.MAX_CREDITS(`ISSUE_BR_CREDITS)) br_credits (
        .clk            (clk),
        .reset_i        (reset_i),
        .consume_i      (br_consume),
        .return_i       (br_credit_i),
        .avail_o        (br_avail),
        .all_returned_o ()
    );

    dispatch_fsm dispatch (
        .clk                (clk),
        .reset_i            (reset_i),
        .head_i             (iq_head),
        .head_valid_i       (!iq_empty),
        .rob_avail_i        (rob_avail),
        .rob_all_returned_i (rob_all_returned),
        .rs_avail_i         (rs_avail),
        .br_avail_i         (br_avail),
        .issue_o            (issue_o),
        .pop_o              (iq_pop),
        .rs_consume_o       (rs_consume),
        .br_consume_o       (br_consume),
        .rob_consume_o      (rob_consume)
    );

endmodule

`default_nettype wire

// File: logic/sync_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module sync_fifo #(
    parameter type DTYPE = logic [31:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic reset_i,
    input  logic push_i,
    input  DTYPE data_i,
    input  logic pop_i,
    output DTYPE data_o,
    output logic empty_o,
    output logic full_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    DTYPE             mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // a push into a full buffer or a pop from an empty one is dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == CNT_W'(DEPTH));

    // head is visible without waiting for the pop
    assign data_o = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the issue stage testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module issue_stage_tb \
    -f issue_stage.f -o issue_stage_sim &&
./obj_dir/issue_stage_sim | tee /dev/stderr | grep -q "All checks passed" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }

// File: verification/issue_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "issue_consts.svh"

module issue_stage_tb;
    import issue_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int N_INSTR      = 2000;
    localparam int WATCHDOG_NS  = N_INSTR * 20 * CLK_PERIOD;
    localparam int QUIET_CYCLES = 2 * `ISSUE_IQ_DEPTH;
    localparam int NUM_TESTS    = 6;
    localparam int T_DECODE     = 0;
    localparam int T_ROUTE      = 1;
    localparam int T_ROB        = 2;
    localparam int T_ALLOC      = 3;
    localparam int T_SERIAL     = 4;
    localparam int T_FETCH      = 5;

    logic                         clk;
    logic                         reset;
    logic                         fetch_valid;
    fetch_pkt_t                   fetch_pkt;
    logic                         fetch_credit;
    logic                         rob_credit;
    logic [`ISSUE_NUM_ALU_RS-1:0] rs_credit;
    logic                         br_credit;
    issue_pkt_t                   issue;

    logic [31:0] rng_state;
    ctl_word_t   exp_q [$];
    int          fetch_credits;
    int          sent;
    int          issued;
    int          rob_out;
    int          br_out;
    int          rs_out [`ISSUE_NUM_ALU_RS];
    int          n_checks [NUM_TESTS];
    int          n_errors [NUM_TESTS];

    issue_stage_top dut (
        .clk            (clk),
        .reset_i        (reset),
        .fetch_valid_i  (fetch_valid),
        .fetch_pkt_i    (fetch_pkt),
        .fetch_credit_o (fetch_credit),
        .rob_credit_i   (rob_credit),
        .rs_credit_i    (rs_credit),
        .br_credit_i    (br_credit),
        .issue_o        (issue)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the issue stage did not finish the instruction stream in time");
        $display("Checks failed");
        $finish;
    end

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic string test_label(int t);
        case (t)
            T_DECODE: return "decode";
            T_ROUTE:  return "routing";
            T_ROB:    return "rob_limit";
            T_ALLOC:  return "regfile_alloc";
            T_SERIAL: return "serialize";
            default:  return "fetch_credit";
        endcase
    endfunction

    // ALU ops weighted up in the opcode table so system ops stay rare
    function automatic logic [6:0] table_opcode(logic [3:0] idx);
        case (idx)
            4'd0:    return 7'b0110111;
            4'd1:    return 7'b0010111;
            4'd2:    return 7'b1101111;
            4'd3:    return 7'b1100111;
            4'd4:    return 7'b1100011;
            4'd5:    return 7'b0000011;
            4'd6:    return 7'b0100011;
            4'd7:    return 7'b0010011;
            4'd8:    return 7'b0010011;
            4'd9:    return 7'b0110011;
            4'd10:   return 7'b0110011;
            4'd11:   return 7'b0001111;
            4'd12:   return 7'b1110011;
            4'd13:   return 7'b1100011;
            4'd14:   return 7'b0110011;
            default: return 7'b1111111;
        endcase
    endfunction

    // reference decode where the rs valid bits follow the instruction format
    function automatic ctl_word_t model_decode(logic [31:0] ins, logic [31:0] pc);
        ctl_word_t          c;
        logic signed [31:0] sins;
        logic signed [31:0] imm;
        logic [6:0]         opc;
        sins = ins;
        opc  = ins[6:0];
        c = '0;
        c.op       = OP_ALU;
        c.funct3   = ins[14:12];
        c.funct7_5 = ins[30];
        c.rs1      = ins[19:15];
        c.rs2      = ins[24:20];
        c.rd       = ins[11:7];
        c.pc       = pc;
        c.next_pc  = pc + 32'd4;
        c.instr    = ins;
        if (opc == 7'b0110111 || opc == 7'b0010111) begin
            c.op  = OP_UPPER;
            c.imm = ins & 32'hffff_f000;
        end else if (opc == 7'b1101111) begin
            c.op  = OP_JUMP;
            imm   = $signed({ins[31], ins[19:12], ins[20], ins[30:21], 1'b0});
            c.imm = imm;
        end else if (opc == 7'b1100011) begin
            c.op  = OP_BRANCH;
            imm   = $signed({ins[31], ins[7], ins[30:25], ins[11:8], 1'b0});
            c.imm = imm;
            c.rs1_valid = 1'b1;
            c.rs2_valid = 1'b1;
        end else if (opc == 7'b0100011) begin
            c.op  = OP_STORE;
            imm   = sins >>> 20;
            c.imm = {imm[31:5], ins[11:7]};
            c.rs1_valid = 1'b1;
            c.rs2_valid = 1'b1;
        end else if (opc == 7'b0110011) begin
            c.rs1_valid = 1'b1;
            c.rs2_valid = 1'b1;
        end else if (opc == 7'b1100111 || opc == 7'b0000011 || opc == 7'b0010011) begin
            c.op  = (opc == 7'b1100111) ? OP_JUMP : (opc == 7'b0000011) ? OP_LOAD : OP_ALU;
            c.imm = sins >>> 20;
            c.rs1_valid = 1'b1;
        end else if (opc == 7'b0001111 || opc == 7'b1110011) begin
            c.op  = OP_SYSTEM;
            c.imm = sins >>> 20;
        end
        return c;
    endfunction

    task automatic compare(int t, string what, logic [63:0] exp, logic [63:0] act);
        n_checks[t]++;
        if (exp !== act) begin
            n_errors[t]++;
            $display("CHECK FAILED %s %s: expected %0h actual %0h", test_label(t), what,
                     exp, act);
        end
    endtask

    task automatic report_failure(int t, string msg);
        n_checks[t]++;
        n_errors[t]++;
        $display("%s: %s", test_label(t), msg);
    endtask

    task automatic check_issue(issue_pkt_t pkt);
        ctl_word_t exp;
        station_t  exp_st;
        logic      found;
        logic      exp_alloc;
        if (exp_q.size() == 0) begin
            report_failure(T_DECODE, "an issue appeared with no instruction outstanding");
            return;
        end
        exp = exp_q.pop_front();
        compare(T_DECODE, "op", 64'(exp.op), 64'(pkt.ctl.op));
        compare(T_DECODE, "funct", {exp.funct3, exp.funct7_5}, {pkt.ctl.funct3, pkt.ctl.funct7_5});
        compare(T_DECODE, "regs", {exp.rs1, exp.rs1_valid, exp.rs2, exp.rs2_valid, exp.rd},
                {pkt.ctl.rs1, pkt.ctl.rs1_valid, pkt.ctl.rs2, pkt.ctl.rs2_valid, pkt.ctl.rd});
        compare(T_DECODE, "imm", exp.imm, pkt.ctl.imm);
        compare(T_DECODE, "pc", {exp.pc, exp.next_pc}, {pkt.ctl.pc, pkt.ctl.next_pc});
        compare(T_DECODE, "instr", exp.instr, pkt.ctl.instr);

        found  = 1'b0;
        exp_st = RS_BR;
        if (exp.op == OP_BRANCH || exp.op == OP_JUMP) begin
            found = (br_out < `ISSUE_BR_CREDITS);
        end else begin
            for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
                if (!found && rs_out[i] < `ISSUE_RS_CREDITS) begin
                    found  = 1'b1;
                    exp_st = station_t'(3'(i));
                end
            end
        end
        if (!found) begin
            report_failure(T_ROUTE, "an instruction issued to a station holding no credit");
        end
        compare(T_ROUTE, "station", 64'(exp_st), 64'(pkt.station));
        compare(T_ROB, "rob entry free", 1, rob_out < `ISSUE_ROB_CREDITS);

        exp_alloc = (exp.rd != '0) && (exp.op != OP_STORE) && (exp.op != OP_BRANCH) &&
                    (exp.op != OP_SYSTEM);
        compare(T_ALLOC, "regfile_alloc", exp_alloc, pkt.regfile_alloc);
        if (exp.op == OP_SYSTEM) begin
            compare(T_SERIAL, "rob outstanding", 0, rob_out);
        end

        // account on the station the DUT chose so later returns stay legal
        rob_out++;
        if (pkt.station == RS_BR) begin
            br_out++;
        end else if (int'(pkt.station) < `ISSUE_NUM_ALU_RS) begin
            rs_out[int'(pkt.station)]++;
        end
    endtask

    task automatic send_instr();
        logic [31:0] r;
        logic [31:0] ins;
        logic [31:0] pc;
        r   = xorshift();
        ins = {r[31:7], table_opcode(r[3:0])};
        pc  = 32'h0000_1000 + 32'(sent) * 32'd4;
        exp_q.push_back(model_decode(ins, pc));
        fetch_pkt.instr = ins;
        fetch_pkt.pc    = pc;
        fetch_valid     = 1'b1;
        fetch_credits--;
        sent++;
    endtask

    // sample outputs first and then drive the next inputs on one falling edge
    task automatic cycle_step();
        logic                         fc;
        issue_pkt_t                   pkt;
        logic [31:0]                  r;
        logic                         rob_ret;
        logic                         br_ret;
        logic [`ISSUE_NUM_ALU_RS-1:0] rs_ret;
        fc  = fetch_credit;
        pkt = issue;
        r   = xorshift();
        rob_ret = (rob_out > 0) && r[0];
        br_ret  = (br_out > 0) && r[1];
        for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
            rs_ret[i] = (rs_out[i] > 0) && (r[2*i+2 +: 2] != 2'b00);
        end
        if (pkt.valid) begin
            issued++;
            check_issue(pkt);
        end
        rob_out = rob_out - int'(rob_ret);
        br_out  = br_out - int'(br_ret);
        for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
            rs_out[i] = rs_out[i] - int'(rs_ret[i]);
        end
        rob_credit = rob_ret;
        br_credit  = br_ret;
        rs_credit  = rs_ret;
        if (sent < N_INSTR && fetch_credits > 0 && r[15:14] != 2'b00) begin
            send_instr();
        end else begin
            fetch_valid = 1'b0;
        end
        // a returned fetch credit is usable from the next cycle on
        if (fc) begin
            fetch_credits++;
        end
    endtask

    function automatic logic drained();
        logic idle;
        idle = (sent == N_INSTR) && (exp_q.size() == 0) && (rob_out == 0) && (br_out == 0);
        for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
            idle = idle && (rs_out[i] == 0);
        end
        return idle;
    endfunction

    initial begin
        int total_checks;
        int total_errors;
        rng_state     = 32'd62530;
        reset         = 1'b1;
        fetch_valid   = 1'b0;
        fetch_pkt     = '0;
        rob_credit    = 1'b0;
        rs_credit     = '0;
        br_credit     = 1'b0;
        fetch_credits = `ISSUE_FETCH_DEPTH;
        sent          = 0;
        issued        = 0;
        rob_out       = 0;
        br_out        = 0;
        for (int i = 0; i < `ISSUE_NUM_ALU_RS; i++) begin
            rs_out[i] = 0;
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            n_checks[t] = 0;
            n_errors[t] = 0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        while (!drained()) begin
            @(negedge clk);
            cycle_step();
        end

        // the stage stays quiet once the whole stream has issued
        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            cycle_step();
        end

        compare(T_FETCH, "fetch credits", `ISSUE_FETCH_DEPTH, fetch_credits);
        compare(T_FETCH, "issue count", sent, issued);

        total_checks = 0;
        total_errors = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            $display("%s: %0d checks, %0d errors", test_label(t), n_checks[t], n_errors[t]);
            total_checks += n_checks[t];
            total_errors += n_errors[t];
        end
        $display("total: %0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
